//--- mipsIsaPkg.sv
/* MIPS ISA definitions used by the hazard controller:
   opcodes, funct codes, function classes and the instruction word views */
package mipsIsaPkg;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // Funct codes under SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_MFLO = 6'b010010;
    localparam logic [5:0] FN_MTLO = 6'b010011;
    localparam logic [5:0] FN_MULT = 6'b011000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;

    // Coarse function class of an instruction
    typedef enum logic [2:0] {
        NOP       = 3'd0,
        CALC_R    = 3'd1,
        CALC_I    = 3'd2,
        MEM_READ  = 3'd3,
        MEM_WRITE = 3'd4,
        BRANCH    = 3'd5,
        JUMP      = 3'd6,
        MULTDIV   = 3'd7
    } funcClass;

    // One 32-bit word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWord;

endpackage

//--- pipeCtrlPkg.sv
/* Pipeline timing types and CP0 control codes */
package pipeCtrlPkg;

    localparam int T_WIDTH = 3; // Enough for Tnew of LB

    // Tuse or Tnew, in cycles
    typedef logic [T_WIDTH-1:0] tTime;

    // Operand never read
    localparam tTime TUSE_INF = 3'd7;

    // CP0 request to the pipeline
    typedef enum logic [1:0] {
        NONE  = 2'd0,
        KTEXT = 2'd1, // Enter handler
        ERET  = 2'd2  // Leave handler
    } kCtrl;

endpackage

//--- InstrClassifier.sv
/* Instruction classifier: decodes the ID instruction into
   function class, Tuse per source, Tnew and destination register */
`timescale 1ns/1ps

module InstrClassifier #(
    parameter int REG_ADDR_WIDTH = 5
) (
    input  mipsIsaPkg::instrWord        instr,
    output mipsIsaPkg::funcClass        instrClass,
    output pipeCtrlPkg::tTime           tuseRs,
    output pipeCtrlPkg::tTime           tuseRt,
    output pipeCtrlPkg::tTime           tnewId,
    output logic [REG_ADDR_WIDTH-1:0]   rsAddr,
    output logic [REG_ADDR_WIDTH-1:0]   rtAddr,
    output logic [REG_ADDR_WIDTH-1:0]   writeAddr,
    output logic                        isJumpBranch
);

    logic isNop; // All-zero word

    assign isNop = (instr.iType.opcode == mipsIsaPkg::OP_SPECIAL) && (instr.iType.rs == '0) &&
                   (instr.iType.rt == '0) && (instr.iType.imm == 16'h0000);

    assign rsAddr = instr.iType.rs;
    assign rtAddr = instr.iType.rt;

    assign isJumpBranch = (instrClass == mipsIsaPkg::BRANCH) || (instrClass == mipsIsaPkg::JUMP);

    always_comb begin
        instrClass = mipsIsaPkg::NOP;
        tuseRs     = pipeCtrlPkg::TUSE_INF;
        tuseRt     = pipeCtrlPkg::TUSE_INF;
        tnewId     = 3'd0;
        writeAddr  = '0;
        case (instr.rType.opcode)
            mipsIsaPkg::OP_SPECIAL: begin
                if (!isNop) begin
                    case (instr.rType.funct)
                        mipsIsaPkg::FN_ADDU, mipsIsaPkg::FN_SUBU, mipsIsaPkg::FN_SLL: begin
                            instrClass = mipsIsaPkg::CALC_R;
                            tuseRs     = (instr.rType.funct == mipsIsaPkg::FN_SLL) ?
                                         pipeCtrlPkg::TUSE_INF : 3'd1; // SLL shifts rt only
                            tuseRt     = 3'd1;
                            tnewId     = 3'd2;
                            writeAddr  = instr.rType.rd;
                        end
                        mipsIsaPkg::FN_JR: begin
                            instrClass = mipsIsaPkg::JUMP;
                            tuseRs     = 3'd0;
                        end
                        mipsIsaPkg::FN_JALR: begin
                            instrClass = mipsIsaPkg::JUMP;
                            tuseRs     = 3'd0;
                            tnewId     = 3'd1; // Link address ready in EX
                            writeAddr  = instr.rType.rd;
                        end
                        mipsIsaPkg::FN_MULT: begin
                            instrClass = mipsIsaPkg::MULTDIV;
                            tuseRs     = 3'd1;
                            tuseRt     = 3'd1;
                        end
                        mipsIsaPkg::FN_MTLO: begin
                            instrClass = mipsIsaPkg::MULTDIV;
                            tuseRs     = 3'd1;
                        end
                        mipsIsaPkg::FN_MFLO: begin
                            instrClass = mipsIsaPkg::MULTDIV;
                            tnewId     = 3'd2;
                            writeAddr  = instr.rType.rd;
                        end
                        default: ; // Unsupported funct treated as NOP
                    endcase
                end
            end
            mipsIsaPkg::OP_ORI, mipsIsaPkg::OP_LUI: begin
                instrClass = mipsIsaPkg::CALC_I;
                // LUI ignores rs and is ready one stage earlier
                tuseRs     = (instr.iType.opcode == mipsIsaPkg::OP_LUI) ?
                             pipeCtrlPkg::TUSE_INF : 3'd1;
                tnewId     = (instr.iType.opcode == mipsIsaPkg::OP_LUI) ? 3'd1 : 3'd2;
                writeAddr  = instr.iType.rt;
            end
            mipsIsaPkg::OP_LW, mipsIsaPkg::OP_LB: begin
                instrClass = mipsIsaPkg::MEM_READ;
                tuseRs     = 3'd1;
                tnewId     = (instr.iType.opcode == mipsIsaPkg::OP_LW) ? 3'd3 : 3'd5;
                writeAddr  = instr.iType.rt;
            end
            mipsIsaPkg::OP_SW: begin
                instrClass = mipsIsaPkg::MEM_WRITE;
                tuseRs     = 3'd1;
                tuseRt     = 3'd2; // Store data needed in MEM
            end
            mipsIsaPkg::OP_BEQ, mipsIsaPkg::OP_BNE: begin
                instrClass = mipsIsaPkg::BRANCH;
                tuseRs     = 3'd0;
                tuseRt     = 3'd0;
            end
            mipsIsaPkg::OP_J: begin
                instrClass = mipsIsaPkg::JUMP;
            end
            mipsIsaPkg::OP_JAL: begin
                instrClass = mipsIsaPkg::JUMP;
                tnewId     = 3'd1;
                writeAddr  = '1; // r31
            end
            default: ;
        endcase
    end

endmodule

//--- HazardDetector.sv
/* Hazard detector: tracks EX/MEM destinations with Tnew countdown
   and requests a stall on unready operands or a busy mult/div unit */
`timescale 1ns/1ps

module HazardDetector #(
    parameter int REG_ADDR_WIDTH = 5
) (
    input  logic                        clk,
    input  logic                        arstN,
    input  pipeCtrlPkg::tTime           tuseRs,
    input  pipeCtrlPkg::tTime           tuseRt,
    input  pipeCtrlPkg::tTime           tnewId,
    input  logic [REG_ADDR_WIDTH-1:0]   rsAddr,
    input  logic [REG_ADDR_WIDTH-1:0]   rtAddr,
    input  logic [REG_ADDR_WIDTH-1:0]   writeAddr,
    input  mipsIsaPkg::funcClass        instrClass,
    input  logic                        mdBusy,
    input  logic                        clrEx,
    input  logic                        clrMem,
    output logic                        stallReq
);

    logic [REG_ADDR_WIDTH-1:0] dstEx;
    logic [REG_ADDR_WIDTH-1:0] dstMem;
    pipeCtrlPkg::tTime         tnewEx;
    pipeCtrlPkg::tTime         tnewMem;
    logic                      stallRs;
    logic                      stallRt;
    logic                      stallMd;

    // One stage closer to the result, saturating at zero
    function automatic pipeCtrlPkg::tTime stepDown(input pipeCtrlPkg::tTime t);
        return (t == 3'd0) ? 3'd0 : t - 3'd1;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dstEx   <= '0;
            tnewEx  <= 3'd0;
            dstMem  <= '0;
            tnewMem <= 3'd0;
        end else begin
            if (clrEx) begin // Bubble into EX
                dstEx  <= '0;
                tnewEx <= 3'd0;
            end else begin
                dstEx  <= writeAddr;
                tnewEx <= stepDown(tnewId);
            end
            if (clrMem) begin
                dstMem  <= '0;
                tnewMem <= 3'd0;
            end else begin
                dstMem  <= dstEx;
                tnewMem <= stepDown(tnewEx);
            end
        end
    end

    // r0 as a source never waits
    assign stallRs = (rsAddr != '0) &&
                     (((dstEx == rsAddr) && (tnewEx > tuseRs)) ||
                      ((dstMem == rsAddr) && (tnewMem > tuseRs)));
    assign stallRt = (rtAddr != '0) &&
                     (((dstEx == rtAddr) && (tnewEx > tuseRt)) ||
                      ((dstMem == rtAddr) && (tnewMem > tuseRt)));

    assign stallMd = mdBusy && (instrClass == mipsIsaPkg::MULTDIV);

    assign stallReq = stallRs || stallRt || stallMd;

endmodule

//--- ExceptionFlush.sv
/* Exception flush: decodes the CP0 request into flushes and write
   disables, and forms the macro PC from the per-stage PC record */
`timescale 1ns/1ps

module ExceptionFlush #(
    parameter int PC_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  pipeCtrlPkg::kCtrl     kCtrlCp0,
    input  logic                  bdCp0,
    input  logic [PC_WIDTH-1:0]   pcIf,
    input  logic [PC_WIDTH-1:0]   pcId,
    input  logic                  isJumpBranch,
    input  logic                  clrEx,
    input  logic                  clrMem,
    input  logic                  clrWb,
    output logic                  flushAll,
    output logic                  disMultDiv,
    output logic                  disDm,
    output logic                  disGrf,
    output logic [PC_WIDTH-1:0]   macroPc
);

    logic [PC_WIDTH-1:0] pcEx;
    logic [PC_WIDTH-1:0] pcMem;
    logic [PC_WIDTH-1:0] pcWb;
    logic                jbEx;
    logic                jbMem;
    logic                jbWb;

    // PC and jump/branch flag shift with the instruction
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcEx  <= '0;
            pcMem <= '0;
            pcWb  <= '0;
            jbEx  <= 1'b0;
            jbMem <= 1'b0;
            jbWb  <= 1'b0;
        end else begin
            pcEx  <= clrEx ? '0 : pcId;
            jbEx  <= clrEx ? 1'b0 : isJumpBranch;
            pcMem <= clrMem ? '0 : pcEx;
            jbMem <= clrMem ? 1'b0 : jbEx;
            pcWb  <= clrWb ? '0 : pcMem;
            jbWb  <= clrWb ? 1'b0 : jbMem;
        end
    end

    assign flushAll   = (kCtrlCp0 == pipeCtrlPkg::KTEXT) || (kCtrlCp0 == pipeCtrlPkg::ERET);
    assign disMultDiv = flushAll;
    assign disDm      = flushAll;
    assign disGrf     = flushAll && bdCp0; // Delay slot victim keeps branch link out

    // Delay slot reports its branch, else oldest live PC
    always_comb begin
        if (jbWb)
            macroPc = pcWb;
        else if (pcMem != '0)
            macroPc = pcMem;
        else if (pcEx != '0)
            macroPc = pcEx;
        else if (pcId != '0)
            macroPc = pcId;
        else
            macroPc = pcIf; // Zero if the pipe is empty
    end

endmodule

//--- ControlMerge.sv
/* Control merge: combines stall and flush requests, flush first */
`timescale 1ns/1ps

module ControlMerge (
    input  logic stallReq,
    input  logic flushAll,
    output logic stallPc,
    output logic stallId,
    output logic clrId,
    output logic clrEx,
    output logic clrMem,
    output logic clrWb
);

    logic stallKept; // Stall surviving the flush

    assign stallKept = stallReq && !flushAll;

    assign stallPc = stallKept;
    assign stallId = stallKept;

    // EX is cleared by a stall bubble or by the flush
    assign clrEx  = stallKept || flushAll;
    assign clrId  = flushAll;
    assign clrMem = flushAll;
    assign clrWb  = flushAll;

endmodule

//--- HazardControlTop.sv
/* Hazard and flush controller of the five-stage pipeline */
`timescale 1ns/1ps

module HazardControlTop #(
    parameter int PC_WIDTH       = 32,
    parameter int REG_ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  mipsIsaPkg::instrWord  instrId,
    input  logic [PC_WIDTH-1:0]   pcIf,
    input  logic [PC_WIDTH-1:0]   pcId,
    input  logic                  mdBusy,
    input  pipeCtrlPkg::kCtrl     kCtrlCp0,
    input  logic                  bdCp0,
    output pipeCtrlPkg::tTime     tnewId,
    output logic [PC_WIDTH-1:0]   macroPc,
    output logic                  stallPc,
    output logic                  stallId,
    output logic                  clrId,
    output logic                  clrEx,
    output logic                  clrMem,
    output logic                  clrWb,
    output logic                  disMultDiv,
    output logic                  disDm,
    output logic                  disGrf
);

    mipsIsaPkg::funcClass        instrClass;
    pipeCtrlPkg::tTime           tuseRs;
    pipeCtrlPkg::tTime           tuseRt;
    logic [REG_ADDR_WIDTH-1:0]   rsAddr;
    logic [REG_ADDR_WIDTH-1:0]   rtAddr;
    logic [REG_ADDR_WIDTH-1:0]   writeAddr;
    logic                        isJumpBranch;
    logic                        stallReq;
    logic                        flushAll;

    InstrClassifier #(.REG_ADDR_WIDTH(REG_ADDR_WIDTH)) classifier0 (
        .instr(instrId), .instrClass(instrClass),
        .tuseRs(tuseRs), .tuseRt(tuseRt), .tnewId(tnewId),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .writeAddr(writeAddr),
        .isJumpBranch(isJumpBranch)
    );

    HazardDetector #(.REG_ADDR_WIDTH(REG_ADDR_WIDTH)) hazard0 (
        .clk(clk), .arstN(arstN),
        .tuseRs(tuseRs), .tuseRt(tuseRt), .tnewId(tnewId),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .writeAddr(writeAddr),
        .instrClass(instrClass), .mdBusy(mdBusy),
        .clrEx(clrEx), .clrMem(clrMem), .stallReq(stallReq)
    );

    ExceptionFlush #(.PC_WIDTH(PC_WIDTH)) flush0 (
        .clk(clk), .arstN(arstN),
        .kCtrlCp0(kCtrlCp0), .bdCp0(bdCp0),
        .pcIf(pcIf), .pcId(pcId), .isJumpBranch(isJumpBranch),
        .clrEx(clrEx), .clrMem(clrMem), .clrWb(clrWb),
        .flushAll(flushAll), .disMultDiv(disMultDiv), .disDm(disDm),
        .disGrf(disGrf), .macroPc(macroPc)
    );

    // Records above advance under these merged controls
    ControlMerge merge0 (
        .stallReq(stallReq), .flushAll(flushAll),
        .stallPc(stallPc), .stallId(stallId),
        .clrId(clrId), .clrEx(clrEx), .clrMem(clrMem), .clrWb(clrWb)
    );

endmodule

//--- hazardControl_assert.sv
/* Concurrent checks on the merged pipeline controls */
`timescale 1ns/1ps

module HazardControlAssert (
    input logic clk,
    input logic arstN,
    input logic stallPc,
    input logic stallId,
    input logic clrId,
    input logic clrEx,
    input logic clrMem,
    input logic clrWb,
    input logic disMultDiv,
    input logic disDm,
    input logic disGrf
);

    int fails = 0; // Failure count, read by the testbench summary

    // Flush always beats stall
    stallVsFlush: assert property (@(posedge clk) disable iff (!arstN) !(stallPc && clrId))
        else begin
            $error("stallPc is high during a flush");
            fails++;
        end

    stallPair: assert property (@(posedge clk) stallPc == stallId)
        else begin
            $error("stallPc and stallId differ");
            fails++;
        end

    quietInReset: assert property (@(posedge clk) !arstN |->
        !(stallPc || stallId || clrId || clrEx || clrMem || clrWb || disMultDiv || disDm || disGrf))
        else begin
            $error("a control is active during reset");
            fails++;
        end

endmodule

bind HazardControlTop HazardControlAssert ha0 (
    .clk(clk), .arstN(arstN), .stallPc(stallPc), .stallId(stallId), .clrId(clrId),
    .clrEx(clrEx), .clrMem(clrMem), .clrWb(clrWb), .disMultDiv(disMultDiv),
    .disDm(disDm), .disGrf(disGrf)
);

//--- HazardControlTb.sv
/* Directed testbench for the hazard and flush controller,
   checked against a small model of the EX/MEM/WB record */
`timescale 1ns/1ps

module HazardControlTb;

    localparam int PW = 32;
    localparam int HALF = 10;
    localparam int MAX_CYCLES = 300; // Tests take about 50 cycles, generous margin
    localparam pipeCtrlPkg::tTime INF = pipeCtrlPkg::TUSE_INF;

    logic                 clk = 1'b0;
    logic                 arstN;
    mipsIsaPkg::instrWord instrId;
    logic [PW-1:0]        pcIf;
    logic [PW-1:0]        pcId;
    logic                 mdBusy;
    pipeCtrlPkg::kCtrl    kCtrlCp0;
    logic                 bdCp0;
    pipeCtrlPkg::tTime    tnewId;
    logic [PW-1:0]        macroPc;
    logic stallPc, stallId, clrId, clrEx, clrMem, clrWb;
    logic disMultDiv, disDm, disGrf;

    // Model record, index 0 is EX, 1 is MEM, 2 is WB
    logic [4:0]        mDst [2];
    pipeCtrlPkg::tTime mTnew [2];
    logic [PW-1:0]     mPc [3];
    logic              mJb [3];

    logic [PW-1:0]     pcNext;     // PC of the next issued instruction
    pipeCtrlPkg::tTime lastStalls; // Stall cycles seen by the last issue
    int                errors = 0;

    HazardControlTop #(.PC_WIDTH(PW), .REG_ADDR_WIDTH(5)) dut0 (
        .clk(clk), .arstN(arstN), .instrId(instrId), .pcIf(pcIf), .pcId(pcId),
        .mdBusy(mdBusy), .kCtrlCp0(kCtrlCp0), .bdCp0(bdCp0), .tnewId(tnewId),
        .macroPc(macroPc), .stallPc(stallPc), .stallId(stallId), .clrId(clrId),
        .clrEx(clrEx), .clrMem(clrMem), .clrWb(clrWb), .disMultDiv(disMultDiv),
        .disDm(disDm), .disGrf(disGrf)
    );

    always #HALF clk = ~clk;

    initial begin
        #(MAX_CYCLES * 2 * HALF);
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic checkTime(input string name, input pipeCtrlPkg::tTime exp,
                             input pipeCtrlPkg::tTime act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkCtrl(input string name, input logic [5:0] exp, input logic [5:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkPc(input string name, input logic [PW-1:0] exp, input logic [PW-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic pipeCtrlPkg::tTime countDown(input pipeCtrlPkg::tTime t);
        return (t == 0) ? t : t - 3'd1;
    endfunction

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs, rt, rd);
        return {mipsIsaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs, rt);
        return {op, rs, rt, 16'h0010};
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(1 + $urandom % 29); // r1 to r29, room for r+2
    endfunction

    function automatic logic [PW-1:0] randPc();
        return 32'h0040_0000 + {16'h0000, 14'($urandom), 2'b00}; // Word aligned, never 0
    endfunction

    // Hold one instruction at ID while stallPc is high, checking every cycle
    task automatic issue(input string name, input logic [31:0] w, input pipeCtrlPkg::tTime tnew,
                         input pipeCtrlPkg::tTime tRs, input pipeCtrlPkg::tTime tRt,
                         input logic [4:0] dst, input logic jb, input logic md);
        logic          stall;
        logic          flush;
        logic          held;
        logic [PW-1:0] expPc;
        int            i;
        instrId    = w;
        pcId       = pcNext;
        pcIf       = (pcNext == 0) ? '0 : pcNext + 32'd4; // Empty front end stays at 0
        lastStalls = 0;
        do begin
            #(HALF / 2);
            flush = (kCtrlCp0 == pipeCtrlPkg::KTEXT) || (kCtrlCp0 == pipeCtrlPkg::ERET);
            stall = md && mdBusy;
            for (i = 0; i < 2; i++) begin
                if (w[25:21] != 0 && mDst[i] == w[25:21] && mTnew[i] > tRs)
                    stall = 1'b1;
                if (w[20:16] != 0 && mDst[i] == w[20:16] && mTnew[i] > tRt)
                    stall = 1'b1;
            end
            stall = stall && !flush; // Flush wins
            if (mJb[2])
                expPc = mPc[2];
            else
                expPc = (mPc[1] != 0) ? mPc[1] : (mPc[0] != 0) ? mPc[0] :
                        (pcId != 0) ? pcId : pcIf;
            checkTime({name, " tnewId"}, tnew, tnewId);
            checkCtrl({name, " controls"}, {stall, stall, flush, stall | flush, flush, flush},
                      {stallPc, stallId, clrId, clrEx, clrMem, clrWb});
            checkCtrl({name, " disables"}, {3'b000, flush, flush, flush & bdCp0},
                      {3'b000, disMultDiv, disDm, disGrf});
            checkPc({name, " macroPc"}, expPc, macroPc);
            held = stallPc;
            if (held)
                lastStalls = lastStalls + 3'd1;
            @(posedge clk);
            // Oldest stage first
            mPc[2]   = flush ? '0 : mPc[1];
            mJb[2]   = !flush && mJb[1];
            mPc[1]   = flush ? '0 : mPc[0];
            mJb[1]   = !flush && mJb[0];
            mDst[1]  = flush ? '0 : mDst[0];
            mTnew[1] = flush ? '0 : countDown(mTnew[0]);
            mPc[0]   = (flush || stall) ? '0 : pcId; // Bubble on stall or flush
            mJb[0]   = !(flush || stall) && jb;
            mDst[0]  = (flush || stall) ? '0 : dst;
            mTnew[0] = (flush || stall) ? '0 : countDown(tnew);
            @(negedge clk);
        end while (held);
        if (pcNext != 0)
            pcNext = pcNext + 32'd4;
    endtask

    task automatic loadUseTest();
        logic [4:0] r;
        r = randReg();
        issue("loadUse lw", encodeI(mipsIsaPkg::OP_LW, 0, r), 3, 1, INF, r, 0, 0);
        issue("loadUse addu", encodeR(mipsIsaPkg::FN_ADDU, r, 0, r + 5'd1), 2, 1, 1,
              r + 5'd1, 0, 0);
        checkTime("loadUse lw stalls", 1, lastStalls);
        issue("loadUse lb", encodeI(mipsIsaPkg::OP_LB, 0, r), 5, 1, INF, r, 0, 0);
        issue("loadUse subu", encodeR(mipsIsaPkg::FN_SUBU, 0, r, r + 5'd2), 2, 1, 1,
              r + 5'd2, 0, 0);
        checkTime("loadUse lb stalls", 2, lastStalls);
    endtask

    // r0, never-read operands and tnewId per class
    task automatic zeroRegTest();
        logic [4:0] r;
        r = randReg();
        issue("zeroReg ori", encodeI(mipsIsaPkg::OP_ORI, 0, 0), 2, 1, INF, 0, 0, 0);
        issue("zeroReg beq", encodeI(mipsIsaPkg::OP_BEQ, 0, 0), 0, 0, 0, 0, 1, 0);
        checkTime("zeroReg beq stalls", 0, lastStalls);
        issue("zeroReg lb", encodeI(mipsIsaPkg::OP_LB, 0, r), 5, 1, INF, r, 0, 0);
        issue("zeroReg lui", encodeI(mipsIsaPkg::OP_LUI, r, r + 5'd1), 1, INF, INF,
              r + 5'd1, 0, 0);
        checkTime("zeroReg lui stalls", 0, lastStalls);
        issue("zeroReg sll", encodeR(mipsIsaPkg::FN_SLL, r, 0, r + 5'd2), 2, INF, 1,
              r + 5'd2, 0, 0);
        checkTime("zeroReg sll stalls", 0, lastStalls);
        issue("zeroReg jal", encodeI(mipsIsaPkg::OP_JAL, 0, 0), 1, INF, INF, 31, 1, 0);
        issue("zeroReg jalr", encodeR(mipsIsaPkg::FN_JALR, 0, 0, r), 1, 0, INF, r, 1, 0);
        issue("zeroReg jr", encodeR(mipsIsaPkg::FN_JR, 0, 0, 0), 0, 0, INF, 0, 1, 0);
        issue("zeroReg j", encodeI(mipsIsaPkg::OP_J, 0, 0), 0, INF, INF, 0, 1, 0);
        issue("zeroReg sw", encodeI(mipsIsaPkg::OP_SW, 0, r), 0, 1, 2, 0, 0, 0);
        issue("zeroReg mflo", encodeR(mipsIsaPkg::FN_MFLO, 0, 0, r), 2, INF, INF, r, 0, 1);
    endtask

    task automatic storeSlackTest();
        logic [4:0] r;
        r = randReg();
        issue("storeSlack addu", encodeR(mipsIsaPkg::FN_ADDU, 0, 0, r), 2, 1, 1, r, 0, 0);
        issue("storeSlack sw", encodeI(mipsIsaPkg::OP_SW, 0, r), 0, 1, 2, 0, 0, 0);
        checkTime("storeSlack sw stalls", 0, lastStalls);
        issue("storeSlack addu2", encodeR(mipsIsaPkg::FN_ADDU, 0, 0, r), 2, 1, 1, r, 0, 0);
        issue("storeSlack beq", encodeI(mipsIsaPkg::OP_BEQ, 0, r), 0, 0, 0, 0, 1, 0);
        checkTime("storeSlack beq stalls", 1, lastStalls);
    endtask

    task automatic mdBusyTest();
        logic [4:0] r;
        r = randReg();
        mdBusy = 1'b1;
        fork
            issue("mdBusy mflo", encodeR(mipsIsaPkg::FN_MFLO, 0, 0, r), 2, INF, INF, r, 0, 1);
            begin
                repeat (3) @(negedge clk);
                mdBusy = 1'b0;
            end
        join
        checkTime("mdBusy mflo stalls", 3, lastStalls);
        mdBusy = 1'b1;
        issue("mdBusy addu", encodeR(mipsIsaPkg::FN_ADDU, 0, 0, r), 2, 1, 1, r, 0, 0);
        checkTime("mdBusy addu stalls", 0, lastStalls);
        fork
            issue("mdBusy mult", encodeR(mipsIsaPkg::FN_MULT, 0, 0, 0), 0, 1, 1, 0, 0, 1);
            begin
                @(negedge clk);
                mdBusy = 1'b0;
            end
        join
        checkTime("mdBusy mult stalls", 1, lastStalls);
    endtask

    task automatic flushTest();
        logic [4:0] r;
        r = randReg();
        issue("flush lw", encodeI(mipsIsaPkg::OP_LW, 0, r), 3, 1, INF, r, 0, 0);
        kCtrlCp0 = pipeCtrlPkg::KTEXT;
        bdCp0    = 1'b1;
        issue("flush ktext", encodeR(mipsIsaPkg::FN_ADDU, r, 0, r + 5'd1), 2, 1, 1,
              r + 5'd1, 0, 0);
        checkTime("flush ktext stalls", 0, lastStalls);
        kCtrlCp0 = pipeCtrlPkg::ERET;
        bdCp0    = 1'b0;
        issue("flush eret", encodeI(mipsIsaPkg::OP_LW, 0, r), 3, 1, INF, r, 0, 0);
        kCtrlCp0 = pipeCtrlPkg::NONE;
        issue("flush after", encodeR(mipsIsaPkg::FN_ADDU, r, r, r + 5'd2), 2, 1, 1,
              r + 5'd2, 0, 0);
        checkTime("flush after stalls", 0, lastStalls);
    endtask

    // Branch walks to WB behind zero PCs, then a plain ALU op does the same
    task automatic macroPcTest();
        pcNext = randPc();
        issue("macroPc beq", encodeI(mipsIsaPkg::OP_BEQ, 0, 0), 0, 0, 0, 0, 1, 0);
        pcNext = '0;
        repeat (3) issue("macroPc nop", '0, 0, INF, INF, 0, 0, 0);
        pcNext = randPc();
        issue("macroPc addu", encodeR(mipsIsaPkg::FN_ADDU, 0, 0, 0), 2, 1, 1, 0, 0, 0);
        pcNext = '0;
        repeat (3) issue("macroPc nop2", '0, 0, INF, INF, 0, 0, 0);
    endtask

    initial begin
        void'($urandom(32'h7cea_eba4));
        arstN    = 1'b0;
        instrId  = '0;
        pcIf     = '0;
        pcId     = '0;
        mdBusy   = 1'b0;
        kCtrlCp0 = pipeCtrlPkg::NONE;
        bdCp0    = 1'b0;
        pcNext   = '0;
        mDst     = '{default: '0};
        mTnew    = '{default: '0};
        mPc      = '{default: '0};
        mJb      = '{default: 1'b0};
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        issue("reset nop", '0, 0, INF, INF, 0, 0, 0); // Empty pipe reports PC 0
        pcNext = randPc();
        loadUseTest();
        zeroRegTest();
        storeSlackTest();
        mdBusyTest();
        flushTest();
        macroPcTest();
        $display("Summary: %0d check errors, %0d assertion failures", errors, dut0.ha0.fails);
        if (errors == 0 && dut0.ha0.fails == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- HazardControlTop.f
mipsIsaPkg.sv
pipeCtrlPkg.sv
InstrClassifier.sv
HazardDetector.sv
ExceptionFlush.sv
ControlMerge.sv
HazardControlTop.sv
hazardControl_assert.sv
HazardControlTb.sv
